// File: hw/id_pkg.sv
// shared widths, types and encodings of the decode stage, imported by every hw module and the testbench
package id_pkg;

    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [ilen-1:0]       inst_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // op_none stays at 0 so a cleared slot decodes to nothing
    typedef enum logic [5:0] {
        op_none,
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        op_addi,
        op_slti,
        op_sltiu,
        op_xori,
        op_ori,
        op_andi,
        op_slli,
        op_srli,
        op_srai,
        op_lb, op_lh, op_lw, op_ld,
        op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_beq, op_bne, op_blt,
        op_bge, op_bltu, op_bgeu,
        op_jal,
        op_jalr,
        op_lui,
        op_auipc
    } op_e;

    // encoding as seen by the execute ALU, 5 is unused
    typedef enum logic [7:0] {
        alu_add  = 8'd0,
        alu_sub  = 8'd1,
        alu_slt  = 8'd2,
        alu_sltu = 8'd3,
        alu_and  = 8'd4,
        alu_or   = 8'd6,
        alu_xor  = 8'd7,
        alu_sll  = 8'd8,
        alu_srl  = 8'd9,
        alu_sra  = 8'd10
    } alu_mode_e;

    localparam logic [6:0] opc_op     = 7'b0110011; // reg-reg
    localparam logic [6:0] opc_op_imm = 7'b0010011; // reg-imm
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

endpackage

// File: hw/id_stage_reg.sv
// fetch-to-decode holding register, loads every cycle and holds while the hazard check stalls
`timescale 1ns/1ps

module id_stage_reg (
    input  logic          clk,
    input  logic          rst,
    input  logic          hold,
    input  logic          valid_in,
    input  id_pkg::xlen_t pc_in,
    input  id_pkg::inst_t inst_in,
    output logic          reg_valid,
    output id_pkg::xlen_t reg_pc,
    output id_pkg::inst_t reg_inst
);

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_valid <= 1'b0;
            reg_pc    <= '0;
            reg_inst  <= '0;
        end else if (!hold) begin
            reg_valid <= valid_in; // taken whatever fetch presents
            reg_pc    <= pc_in;
            reg_inst  <= inst_in;
        end
    end

    // a stalled instruction waits unchanged until its sources are free
    hold_keeps_slot: assert property (
        @(posedge clk) disable iff (rst)
        hold |=> $stable({reg_valid, reg_pc, reg_inst})
    ) else $error("decode slot changed while held");

endmodule

// File: hw/inst_decoder.sv
// instruction decoder, maps an RV64I word to one operation plus register fields and source usage
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::inst_t    inst,
    output id_pkg::op_e      op,
    output id_pkg::reg_idx_t rd,
    output id_pkg::reg_idx_t rs1,
    output id_pkg::reg_idx_t rs2,
    output logic             uses_rs1,
    output logic             uses_rs2
);
    import id_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26]; // rv64 shifts use 6-bit shamt

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    always_comb begin
        op = op_none;
        case (opcode)
            opc_op: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = op_add;
                    10'b0100000_000: op = op_sub;
                    10'b0000000_001: op = op_sll;
                    10'b0000000_010: op = op_slt;
                    10'b0000000_011: op = op_sltu;
                    10'b0000000_100: op = op_xor;
                    10'b0000000_101: op = op_srl;
                    10'b0100000_101: op = op_sra;
                    10'b0000000_110: op = op_or;
                    10'b0000000_111: op = op_and;
                    default:         op = op_none; // incl. mul/div
                endcase
            end
            opc_op_imm: begin
                case ({funct6, funct3})
                    9'b000000_001: op = op_slli;
                    9'b000000_101: op = op_srli;
                    9'b010000_101: op = op_srai;
                    default: begin
                        case (funct3)
                            3'b000:  op = op_addi;
                            3'b010:  op = op_slti;
                            3'b011:  op = op_sltiu;
                            3'b100:  op = op_xori;
                            3'b110:  op = op_ori;
                            3'b111:  op = op_andi;
                            default: op = op_none; // bad shift funct6
                        endcase
                    end
                endcase
            end
            opc_load: begin
                case (funct3)
                    3'b000:  op = op_lb;
                    3'b001:  op = op_lh;
                    3'b010:  op = op_lw;
                    3'b011:  op = op_ld;
                    3'b100:  op = op_lbu;
                    3'b101:  op = op_lhu;
                    3'b110:  op = op_lwu;
                    default: op = op_none;
                endcase
            end
            opc_store: begin
                case (funct3)
                    3'b000:  op = op_sb;
                    3'b001:  op = op_sh;
                    3'b010:  op = op_sw;
                    3'b011:  op = op_sd;
                    default: op = op_none;
                endcase
            end
            opc_branch: begin
                case (funct3)
                    3'b000:  op = op_beq;
                    3'b001:  op = op_bne;
                    3'b100:  op = op_blt;
                    3'b101:  op = op_bge;
                    3'b110:  op = op_bltu;
                    3'b111:  op = op_bgeu;
                    default: op = op_none;
                endcase
            end
            opc_jalr:  op = (funct3 == 3'b000) ? op_jalr : op_none;
            opc_jal:   op = op_jal;
            opc_lui:   op = op_lui;
            opc_auipc: op = op_auipc;
            default:   op = op_none;
        endcase
    end

    assign uses_rs1 = !(op inside {op_none, op_lui, op_auipc, op_jal});
    assign uses_rs2 = (op != op_none) && (opcode inside {opc_op, opc_store, opc_branch});

endmodule

// File: hw/imm_gen.sv
// immediate generator, builds the sign-extended I, S, U and J immediates and the shift amount
`timescale 1ns/1ps

module imm_gen (
    input  id_pkg::inst_t inst,
    output id_pkg::xlen_t imm_i,
    output id_pkg::xlen_t imm_s,
    output id_pkg::xlen_t imm_u,
    output id_pkg::xlen_t imm_j,
    output logic [5:0]    shamt
);
    import id_pkg::*;

    logic sign;

    assign sign = inst[31]; // every format sign-extends from here

    // loads, jalr, arithmetic immediates
    assign imm_i = {{(xlen-12){sign}}, inst[31:20]};

    // split store offset
    assign imm_s = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};

    // lui/auipc, low 12 bits zero
    assign imm_u = {{(xlen-32){sign}}, inst[31:12], 12'b0};

    // jal offset, halfword aligned
    assign imm_j = {
        {(xlen-21){sign}},
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign shamt = inst[25:20]; // 6 bits on rv64

endmodule

// File: hw/hazard_check.sv
// scoreboard hazard check, stalls decode while a source register has a write pending
`timescale 1ns/1ps

module hazard_check (
    input  logic                        uses_rs1,
    input  logic                        uses_rs2,
    input  id_pkg::reg_idx_t            rs1,
    input  id_pkg::reg_idx_t            rs2,
    input  logic [id_pkg::num_regs-1:0] gpr_busy,
    output logic                        stall
);

    logic rs1_busy;
    logic rs2_busy;

    // x0 is checked like any other register
    assign rs1_busy = uses_rs1 && gpr_busy[rs1];
    assign rs2_busy = uses_rs2 && gpr_busy[rs2];

    assign stall = rs1_busy || rs2_busy;

    // lui/auipc/jal and illegal words must always pass
    always_comb begin
        if (!uses_rs1 && !uses_rs2) begin
            assert (!stall) else $error("stall without any source in use");
        end
    end

endmodule

// File: hw/operand_mux.sv
// operand and ALU-mode selector, picks the execute operands and write enable per operation
`timescale 1ns/1ps

module operand_mux (
    input  id_pkg::op_e       op,
    input  id_pkg::xlen_t     src1,
    input  id_pkg::xlen_t     src2_val,
    input  id_pkg::xlen_t     pc,
    input  id_pkg::xlen_t     imm_i,
    input  id_pkg::xlen_t     imm_s,
    input  id_pkg::xlen_t     imm_u,
    input  id_pkg::xlen_t     imm_j,
    input  logic [5:0]        shamt,
    output id_pkg::xlen_t     alu_a,
    output id_pkg::xlen_t     alu_b,
    output id_pkg::alu_mode_e alu_mode,
    output logic              wen
);
    import id_pkg::*;

    xlen_t shamt_ext;
    xlen_t src2_shamt;
    logic  is_store;
    logic  is_branch;

    assign shamt_ext  = {{(xlen-6){1'b0}}, shamt};
    assign src2_shamt = {{(xlen-6){1'b0}}, src2_val[5:0]}; // reg shifts use low 6 bits

    assign is_store  = op inside {op_sb, op_sh, op_sw, op_sd};
    assign is_branch = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};

    always_comb begin
        case (op)
            op_none:          alu_a = '0;
            op_lui:           alu_a = imm_u;
            op_auipc, op_jal: alu_a = pc;
            default:          alu_a = src1;
        endcase
    end

    always_comb begin
        case (op)
            op_add, op_sub, op_slt, op_sltu,
            op_xor, op_or, op_and:          alu_b = src2_val;
            op_sll, op_srl, op_sra:         alu_b = src2_shamt;
            op_slli, op_srli, op_srai:      alu_b = shamt_ext;
            op_addi, op_slti, op_sltiu,
            op_xori, op_ori, op_andi,
            op_lb, op_lh, op_lw, op_ld,
            op_lbu, op_lhu, op_lwu,
            op_jalr:                        alu_b = imm_i;
            op_sb, op_sh, op_sw, op_sd:     alu_b = imm_s;
            op_beq, op_bne, op_blt,
            op_bge, op_bltu, op_bgeu:       alu_b = src2_val; // compare by subtract
            op_auipc:                       alu_b = imm_u;
            op_jal:                         alu_b = imm_j;
            default:                        alu_b = '0; // lui and none
        endcase
    end

    always_comb begin
        case (op)
            op_sub:            alu_mode = alu_sub;
            op_slt, op_slti:   alu_mode = alu_slt;
            op_sltu, op_sltiu: alu_mode = alu_sltu;
            op_and, op_andi:   alu_mode = alu_and;
            op_or, op_ori:     alu_mode = alu_or;
            op_xor, op_xori:   alu_mode = alu_xor;
            op_sll, op_slli:   alu_mode = alu_sll;
            op_srl, op_srli:   alu_mode = alu_srl;
            op_sra, op_srai:   alu_mode = alu_sra;
            default:           alu_mode = is_branch ? alu_sub : alu_add;
        endcase
    end

    assign wen = (op != op_none) && !is_store && !is_branch;

    always_comb begin
        if (is_store || is_branch) begin
            assert (!wen) else $error("register write on store or branch");
        end
    end

endmodule

// File: hw/id_stage.sv
// decode stage top, holding register followed by decode, immediates, hazard check and operand select
`timescale 1ns/1ps

module id_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_in,
    input  id_pkg::xlen_t               pc_in,
    input  id_pkg::inst_t               inst_in,
    input  id_pkg::xlen_t               gpr [id_pkg::num_regs],
    input  logic [id_pkg::num_regs-1:0] gpr_busy,
    output logic                        ready_out,
    output logic                        valid_out,
    output id_pkg::xlen_t               pc_out,
    output id_pkg::inst_t               inst_out,
    output id_pkg::xlen_t               alu_a,
    output id_pkg::xlen_t               alu_b,
    output id_pkg::alu_mode_e           alu_mode,
    output id_pkg::xlen_t               src2,
    output id_pkg::reg_idx_t            rd,
    output logic                        wen
);
    import id_pkg::*;

    logic       reg_valid;
    xlen_t      reg_pc;
    inst_t      reg_inst;
    inst_t      inst_eff;
    op_e        op;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       stall;
    xlen_t      src1;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    xlen_t      imm_j;
    logic [5:0] shamt;

    id_stage_reg u_reg (
        .clk       (clk),
        .rst       (rst),
        .hold      (stall),
        .valid_in  (valid_in),
        .pc_in     (pc_in),
        .inst_in   (inst_in),
        .reg_valid (reg_valid),
        .reg_pc    (reg_pc),
        .reg_inst  (reg_inst)
    );

    assign inst_eff = reg_valid ? reg_inst : '0; // bubble decodes as op_none

    inst_decoder u_dec (
        .inst     (inst_eff),
        .op       (op),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2)
    );

    imm_gen u_imm (
        .inst  (inst_eff),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_u (imm_u),
        .imm_j (imm_j),
        .shamt (shamt)
    );

    hazard_check u_hazard (
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2),
        .rs1      (rs1),
        .rs2      (rs2),
        .gpr_busy (gpr_busy),
        .stall    (stall)
    );

    assign src1 = gpr[rs1];
    assign src2 = gpr[rs2]; // store data and branch operand

    operand_mux u_mux (
        .op       (op),
        .src1     (src1),
        .src2_val (src2),
        .pc       (reg_pc),
        .imm_i    (imm_i),
        .imm_s    (imm_s),
        .imm_u    (imm_u),
        .imm_j    (imm_j),
        .shamt    (shamt),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .alu_mode (alu_mode),
        .wen      (wen)
    );

    assign ready_out = !stall;

    // nothing leaves toward execute while stalled
    assign valid_out = stall ? 1'b0 : reg_valid;
    assign pc_out    = stall ? '0 : reg_pc;
    assign inst_out  = stall ? '0 : reg_inst;

endmodule

// File: testbench/tb_clock.sv
// clock and reset source of the decode-stage testbench, 40 ns clock and reset over the first 5 edges
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0; // released off the edge like other stimulus
    end

endmodule

// File: testbench/tb_ref_model.svh
// reference model of the decode stage that the testbench includes to encode random words and predict outputs
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

xlen_t     gpr [num_regs]; // register file shown to the DUT
xlen_t     exp_a;
xlen_t     exp_b;
alu_mode_e exp_mode;
logic      exp_wen;
logic      exp_use1;
logic      exp_use2;

function automatic xlen_t sext12(input logic [11:0] v);
    return {{(xlen-12){v[11]}}, v};
endfunction

// funct3 meaning shared by register and immediate arithmetic
function automatic alu_mode_e mode_of(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? alu_sub : alu_add;
        3'd1:    return alu_sll;
        3'd2:    return alu_slt;
        3'd3:    return alu_sltu;
        3'd4:    return alu_xor;
        3'd5:    return alt ? alu_sra : alu_srl;
        3'd6:    return alu_or;
        default: return alu_and;
    endcase
endfunction

// empty slot or unknown word
task automatic bubble_expect();
    exp_a    = '0;
    exp_b    = '0;
    exp_mode = alu_add;
    exp_wen  = 1'b0;
    exp_use1 = 1'b0;
    exp_use2 = 1'b0;
endtask

task automatic make_case(input xlen_t pc, output inst_t w);
    int unsigned kind;
    int unsigned sel;
    reg_idx_t    r1;
    reg_idx_t    r2;
    reg_idx_t    rdx;
    logic [11:0] imm;
    logic [19:0] up;
    logic [5:0]  sh;
    logic [2:0]  f3;
    logic        alt;
    xlen_t       uimm;
    logic [20:0] joff;
    r1       = reg_idx_t'($urandom);
    r2       = reg_idx_t'($urandom);
    rdx      = reg_idx_t'($urandom);
    imm      = 12'($urandom);
    up       = 20'($urandom);
    sh       = 6'($urandom);
    f3       = 3'($urandom);
    alt      = 1'($urandom);
    kind     = $urandom % 12;
    sel      = $urandom;
    uimm     = {{32{up[19]}}, up, 12'b0};
    exp_a    = gpr[r1];
    exp_b    = sext12(imm);
    exp_mode = alu_add;
    exp_wen  = 1'b1;
    exp_use1 = 1'b1;
    exp_use2 = 1'b0;
    case (kind)
        0: begin // register-register
            alt      = alt && (f3 == 3'd0 || f3 == 3'd5);
            w        = {1'b0, alt, 5'b0, r2, r1, f3, rdx, opc_op};
            exp_b    = (f3 == 3'd1 || f3 == 3'd5) ? {58'b0, gpr[r2][5:0]} : gpr[r2];
            exp_mode = mode_of(f3, alt);
            exp_use2 = 1'b1;
        end
        1: begin
            sel      = sel % 6;
            f3       = 3'(sel + (sel > 0) + (sel > 3)); // skips the shift codes
            w        = {imm, r1, f3, rdx, opc_op_imm};
            exp_mode = mode_of(f3, 1'b0);
        end
        2: begin // shifts by immediate with 6-bit shamt
            f3       = (sel % 3 == 0) ? 3'd1 : 3'd5;
            alt      = (sel % 3 == 2);
            w        = {1'b0, alt, 4'b0, sh, r1, f3, rdx, opc_op_imm};
            exp_b    = {58'b0, sh};
            exp_mode = mode_of(f3, alt);
        end
        3: w = {imm, r1, 3'(sel % 7), rdx, opc_load};
        4: w = {imm, r1, 3'b000, rdx, opc_jalr};
        5: begin
            w        = {imm[11:5], r2, r1, 3'(sel % 4), imm[4:0], opc_store};
            exp_wen  = 1'b0;
            exp_use2 = 1'b1;
        end
        6: begin // compare by subtract
            f3       = 3'((sel % 6) + ((sel % 6 > 1) ? 2 : 0));
            w        = {imm[11:5], r2, r1, f3, imm[4:0], opc_branch};
            exp_b    = gpr[r2];
            exp_mode = alu_sub;
            exp_wen  = 1'b0;
            exp_use2 = 1'b1;
        end
        7: begin
            w        = {up, rdx, opc_lui};
            exp_a    = uimm;
            exp_b    = '0;
            exp_use1 = 1'b0;
        end
        8: begin
            w        = {up, rdx, opc_auipc};
            exp_a    = pc;
            exp_b    = uimm;
            exp_use1 = 1'b0;
        end
        9: begin // offset bits scrambled in the word
            joff     = {up, 1'b0};
            w        = {joff[20], joff[10:1], joff[11], joff[19:12], rdx, opc_jal};
            exp_a    = pc;
            exp_b    = {{43{joff[20]}}, joff};
            exp_use1 = 1'b0;
        end
        default: begin
            case (sel % 7)
                0:       w = {25'($urandom), 7'h7f};
                1:       w = {7'h01, r2, r1, f3, rdx, opc_op}; // M extension
                2:       w = {imm, r1, 3'b111, rdx, opc_load};
                3:       w = {imm[11:5], r2, r1, 1'b1, f3[1:0], imm[4:0], opc_store};
                4:       w = {imm[11:5], r2, r1, 2'b01, f3[0], imm[4:0], opc_branch};
                5:       w = {imm, r1, f3 | 3'b001, rdx, opc_jalr};
                default: w = {sh | 6'h01, sh, r1, 3'b001, rdx, opc_op_imm};
            endcase
            bubble_expect();
        end
    endcase
endtask

`endif

// File: testbench/tb_id_stage.sv
// top testbench of the decode stage that drives random words and busy patterns and checks every output
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int num_cases  = 600;
    localparam int wait_limit = 16;

    logic                clk;
    logic                rst;
    logic                valid_in;
    xlen_t               pc_in;
    inst_t               inst_in;
    logic [num_regs-1:0] gpr_busy;
    logic                ready_out;
    logic                valid_out;
    xlen_t               pc_out;
    inst_t               inst_out;
    xlen_t               alu_a;
    xlen_t               alu_b;
    alu_mode_e           alu_mode;
    xlen_t               src2;
    reg_idx_t            rd;
    logic                wen;
    int                  errors;
    int                  checks;
    int                  stalls;

    `include "tb_ref_model.svh"

    tb_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    id_stage UUT (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .pc_in     (pc_in),
        .inst_in   (inst_in),
        .gpr       (gpr),
        .gpr_busy  (gpr_busy),
        .ready_out (ready_out),
        .valid_out (valid_out),
        .pc_out    (pc_out),
        .inst_out  (inst_out),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_mode  (alu_mode),
        .src2      (src2),
        .rd        (rd),
        .wen       (wen)
    );

    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input string what, input inst_t got, input inst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mode(input alu_mode_e got, input alu_mode_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: alu_mode is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs(input logic stalled, input logic v, input xlen_t pc,
                                 input inst_t w);
        inst_t eff;
        eff = v ? w : '0;
        check_bit("ready_out", ready_out, !stalled);
        check_bit("valid_out", valid_out, v && !stalled);
        check_word("pc_out", pc_out, stalled ? '0 : pc);
        check_inst("inst_out", inst_out, stalled ? '0 : w);
        check_word("alu_a", alu_a, exp_a);
        check_word("alu_b", alu_b, exp_b);
        check_mode(alu_mode, exp_mode);
        check_bit("wen", wen, exp_wen);
        check_idx("rd", rd, eff[11:7]);
        check_word("src2", src2, gpr[eff[24:20]]);
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        @(negedge clk);
        while (rst !== 1'b0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was never released");
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (ready_out !== 1'b1 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (ready_out !== 1'b1) begin
            $display("timeout: ready_out stayed low with no busy registers");
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    // accepts one instruction, applies a busy pattern and releases it if stalled
    task automatic run_case();
        logic                v;
        xlen_t               pc;
        inst_t               w;
        inst_t               eff;
        logic [num_regs-1:0] busy;
        logic                stall_exp;
        int unsigned         busy_kind;
        int unsigned         hold_cycles;
        wait_ready();
        @(posedge clk);
        #2;
        gpr[reg_idx_t'($urandom)] = {$urandom, $urandom};
        pc = {$urandom, $urandom} & ~xlen_t'(3);
        v  = ($urandom % 8) != 0; // some bubbles
        make_case(pc, w);
        if (!v) begin
            bubble_expect();
        end
        eff      = v ? w : '0;
        valid_in = v;
        pc_in    = pc;
        inst_in  = w;
        gpr_busy = '0;
        @(posedge clk);
        #2;
        busy_kind = $urandom % 4;
        busy      = (busy_kind == 0) ? '0 : (busy_kind == 3) ? '1 : $urandom & $urandom;
        gpr_busy  = busy;
        valid_in  = 1'($urandom); // junk that must not enter while held
        pc_in     = {$urandom, $urandom};
        inst_in   = $urandom;
        stall_exp = (exp_use1 && busy[eff[19:15]]) || (exp_use2 && busy[eff[24:20]]);
        @(negedge clk);
        check_outputs(stall_exp, v, pc, w);
        if (stall_exp) begin
            stalls++;
            hold_cycles = 1 + $urandom % 3;
            repeat (hold_cycles) begin
                @(posedge clk);
                @(negedge clk);
                check_outputs(1'b1, v, pc, w);
            end
            @(posedge clk);
            #2;
            gpr_busy = '0; // leaves in this same cycle
            @(negedge clk);
            check_outputs(1'b0, v, pc, w);
        end
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        stalls   = 0;
        valid_in = 1'b1; // fetch already presenting during reset
        pc_in    = '0;
        inst_in  = 32'h00108093; // addi x1, x1, 1
        gpr_busy = '0;
        void'($urandom(32'he664b68b));
        foreach (gpr[i]) begin
            gpr[i] = {$urandom, $urandom};
        end
        wait_reset_done();
        check_bit("ready_out", ready_out, 1'b1);
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("wen", wen, 1'b0);
        repeat (num_cases) run_case();
        $display("checks %0d, errors %0d, stalls %0d", checks, errors, stalls);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+testbench
hw/id_pkg.sv
hw/id_stage_reg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/hazard_check.sv
hw/operand_mux.sv
hw/id_stage.sv
testbench/tb_clock.sv
testbench/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# builds the decode-stage testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_id_stage -Mdir obj_dir \
    && ./obj_dir/Vtb_id_stage > sim.log 2>&1 \
    ; cat sim.log \
    ; grep -q "TEST RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
